// File: include/rom_dl_config.svh
`ifndef ROM_DL_CONFIG_SVH
`define ROM_DL_CONFIG_SVH

// prom sizes, in address bits
`define CHAR_AW     10          // 1024 pattern bytes
`define PAL_AW      8           // 256 palette entries

// wishbone side, word addressed, 32-bit data
`define WB_AW       16
`define WB_DW       32

// region bases on the download bus
`define CHAR_BASE   16'h0000
`define PAL_BASE    16'h1000
`define CSUM_ADDR   16'h2000    // single register, not a window

`define CSUM_W      16          // running sum width, wraps mod 2^16

`endif

// File: rtl/rom_map_pkg.sv
`include "rom_dl_config.svh"

package rom_map_pkg;

    // raw word address as seen on the bus
    typedef logic [`WB_AW-1:0] wb_addr_t;

    // where a bus access lands
    typedef enum logic [1:0] {
        REG_CHAR = 2'd0,    // character pattern prom
        REG_PAL  = 2'd1,    // palette prom
        REG_CSUM = 2'd2,    // checksum register
        REG_NONE = 2'd3     // unmapped, acked and dropped
    } region_e;

    // decoded address: target plus offset from that region's base
    typedef struct packed {
        region_e  region;
        wb_addr_t offset;
    } dl_addr_t;

    // a char window and a palette window are each 4k words wide,
    // the proms only fill the bottom of it
    localparam int unsigned WIN_WORDS = `PAL_BASE - `CHAR_BASE;

endpackage

// File: rtl/video_pkg.sv
package video_pkg;

    // one row of a character tile, 8 pixels at 1 bit
    typedef logic [7:0] char_byte_t;

    // single colour channel
    typedef logic [3:0] col4_t;

    // palette entry, red in the top nibble as on the bus
    typedef struct packed {
        col4_t r;   // 11:8
        col4_t g;   // 7:4
        col4_t b;   // 3:0
    } rgb444_t;

endpackage

// File: rtl/dl_wr_if.sv
`timescale 1ns/1ps
`include "rom_dl_config.svh"

interface dl_wr_if import video_pkg::*; ();

    logic [`WB_AW-1:0] wr_addr;      // offset inside the selected region
    char_byte_t        char_wdata;
    rgb444_t           pal_wdata;
    logic              char_we;      // single cycle, ack cycle
    logic              pal_we;
    logic              sum_clr;      // clears both running sums

    // bus slave owns every signal
    modport drv (output wr_addr, char_wdata, pal_wdata, char_we, pal_we, sum_clr);

    // prom write side
    modport mem (input wr_addr, char_wdata, pal_wdata, char_we, pal_we);

    // checksum unit only needs strobes and data
    modport mon (input char_wdata, pal_wdata, char_we, pal_we, sum_clr);

endinterface

// File: rtl/prom_mem.sv
`timescale 1ns/1ps

module prom_mem import rom_map_pkg::*; #(
    parameter type     word_t   = logic [7:0],
    parameter int      AW       = 10,
    parameter bit      READ_CEN = 1'b0,      // 1: read reg only moves under cen
    parameter region_e WHICH    = REG_CHAR   // picks strobe and data field
) (
    input  logic          clk,
    input  logic          cen,               // game side clock enable
    input  logic [AW-1:0] rd_addr,
    output word_t         q,
    dl_wr_if.mem          wr
);

    word_t cells [0:(1<<AW)-1];
    logic  we;
    word_t wdata;

    // pick our half of the download bus
    generate
        if (WHICH == REG_PAL) begin : g_pal
            assign we    = wr.pal_we;
            assign wdata = wr.pal_wdata;
        end else begin : g_char
            assign we    = wr.char_we;
            assign wdata = wr.char_wdata;
        end
    endgenerate

    // blank rom until the host fills it
    initial begin
        for (int i = 0; i < (1 << AW); i++) cells[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (!READ_CEN || cen) q <= cells[rd_addr];     // hold while video is paused
        // write side ignores cen, download keeps going with the game stopped
        if (we) cells[wr.wr_addr[AW-1:0]] <= wdata;    // slave already range checked
    end

endmodule

// File: rtl/dl_wb_slave.sv
`timescale 1ns/1ps
`include "rom_dl_config.svh"

module dl_wb_slave import rom_map_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  wb_addr_t            wb_adr,
    input  logic [`WB_DW-1:0]   wb_dat_i,
    output logic [`WB_DW-1:0]   wb_dat_o,
    output logic                wb_ack,
    input  logic [`CSUM_W-1:0]  char_sum,
    input  logic [`CSUM_W-1:0]  pal_sum,
    dl_wr_if.drv                wr
);

    dl_addr_t dec;              // decoded current address
    logic     req;              // new strobe this cycle
    logic     char_hit;         // inside char prom depth
    logic     pal_hit;
    logic     csum_hit;

    // a strobe counts once, the ack cycle itself is not a new request
    assign req = wb_cyc & wb_stb & ~wb_ack;

    // region decode
    always_comb begin
        dec.region = REG_NONE;
        dec.offset = '0;
        if (wb_adr == `CSUM_ADDR) begin
            dec.region = REG_CSUM;
        end else if (wb_adr >= `PAL_BASE && wb_adr < `CSUM_ADDR) begin
            dec.region = REG_PAL;
            dec.offset = wb_adr - `PAL_BASE;
        end else if (wb_adr < `PAL_BASE) begin
            dec.region = REG_CHAR;                      // char window starts at base 0
            dec.offset = wb_adr - `CHAR_BASE;
        end
    end

    // depth check, offsets past the prom size fall on the floor
    assign char_hit = (dec.region == REG_CHAR) && (dec.offset[`WB_AW-1:`CHAR_AW] == '0);
    assign pal_hit  = (dec.region == REG_PAL)  && (dec.offset[`WB_AW-1:`PAL_AW] == '0);
    assign csum_hit = (dec.region == REG_CSUM);

    // control: ack and strobes all land in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            wr.char_we <= 1'b0;
            wr.pal_we  <= 1'b0;
            wr.sum_clr <= 1'b0;
        end else begin
            wb_ack     <= req;                          // always one cycle, no waits
            wr.char_we <= req & wb_we & char_hit;
            wr.pal_we  <= req & wb_we & pal_hit;
            wr.sum_clr <= req & wb_we & csum_hit;       // any data value clears
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        wr.wr_addr    <= dec.offset;
        wr.char_wdata <= wb_dat_i[7:0];
        wr.pal_wdata  <= wb_dat_i[11:0];                // r 11:8, g 7:4, b 3:0
        // readback registered with ack, sums already include an earlier write
        if (req && !wb_we && csum_hit)
            wb_dat_o <= {pal_sum, char_sum};
        else
            wb_dat_o <= '0;                             // proms not readable here
    end

endmodule

// File: rtl/dl_checksum.sv
`timescale 1ns/1ps
`include "rom_dl_config.svh"

module dl_checksum (
    input  logic               clk,
    input  logic               rst,
    dl_wr_if.mon               wr,
    output logic [`CSUM_W-1:0] char_sum,
    output logic [`CSUM_W-1:0] pal_sum
);

    logic [`CSUM_W-1:0] char_term;   // written byte, zero extended
    logic [`CSUM_W-1:0] pal_term;    // written colour as a 12-bit number

    assign char_term = `CSUM_W'(wr.char_wdata);
    assign pal_term  = `CSUM_W'(wr.pal_wdata);

    // character region sum
    always_ff @(posedge clk) begin
        if (rst) begin
            char_sum <= '0;
        end else if (wr.sum_clr) begin
            char_sum <= '0;                       // clear beats a write
        end else if (wr.char_we) begin
            char_sum <= char_sum + char_term;     // wraps mod 2^16
        end
    end

    // palette region sum
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_sum <= '0;
        end else if (wr.sum_clr) begin
            pal_sum <= '0;
        end else if (wr.pal_we) begin
            pal_sum <= pal_sum + pal_term;
        end
    end

endmodule

// File: rtl/rom_dl_top.sv
`timescale 1ns/1ps
`include "rom_dl_config.svh"

module rom_dl_top import rom_map_pkg::*, video_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // host download port, wishbone classic
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [`WB_AW-1:0]   wb_adr,
    input  logic [`WB_DW-1:0]   wb_dat_i,
    output logic [`WB_DW-1:0]   wb_dat_o,
    output logic                wb_ack,
    // game side, character patterns
    input  logic                char_cen,
    input  logic [`CHAR_AW-1:0] char_addr,
    output logic [7:0]          char_q,
    // game side, palette lookup
    input  logic [`PAL_AW-1:0]  pal_addr,
    output logic [11:0]         pal_rgb     // r 11:8, g 7:4, b 3:0
);

    logic [`CSUM_W-1:0] char_sum;
    logic [`CSUM_W-1:0] pal_sum;

    dl_wr_if dl_wr ();                      // download write bus

    dl_wb_slave u_slave (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .char_sum (char_sum),
        .pal_sum  (pal_sum),
        .wr       (dl_wr.drv)
    );

    dl_checksum u_sum (
        .clk      (clk),
        .rst      (rst),
        .wr       (dl_wr.mon),
        .char_sum (char_sum),
        .pal_sum  (pal_sum)
    );

    // char rom follows the game's pixel enable
    prom_mem #(.word_t(char_byte_t), .AW(`CHAR_AW), .READ_CEN(1'b1), .WHICH(REG_CHAR))
    u_char_prom (
        .clk     (clk),
        .cen     (char_cen),
        .rd_addr (char_addr),
        .q       (char_q),
        .wr      (dl_wr.mem)
    );

    // palette looked up every clock
    prom_mem #(.word_t(rgb444_t), .AW(`PAL_AW), .READ_CEN(1'b0), .WHICH(REG_PAL))
    u_pal_prom (
        .clk     (clk),
        .cen     (1'b1),
        .rd_addr (pal_addr),
        .q       (pal_rgb),
        .wr      (dl_wr.mem)
    );

endmodule

// File: tb/rom_dl_sva.sv
`timescale 1ns/1ps

module rom_dl_sva (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);

    int fail_cnt = 0;       // failed properties so far

    // classic handshake, ack is a single pulse per strobe
    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
    ) else begin
        $error("wb_ack high for two cycles in a row");
        fail_cnt++;
    end

    // ack only answers a strobe seen one edge earlier
    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (rst) wb_ack |-> $past(wb_cyc && wb_stb)
    ) else begin
        $error("wb_ack without cyc and stb in the previous cycle");
        fail_cnt++;
    end

    a_ack_low_after_rst: assert property (
        @(posedge clk) rst |=> !wb_ack      // reset clears the ack flop
    ) else begin
        $error("wb_ack high in the cycle after reset");
        fail_cnt++;
    end

endmodule

// File: tb/rom_dl_checker.sv
`timescale 1ns/1ps
`include "rom_dl_config.svh"

module rom_dl_checker import video_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [`WB_AW-1:0]   wb_adr,
    input  logic [`WB_DW-1:0]   wb_dat_i,
    input  logic [`WB_DW-1:0]   wb_dat_o,
    input  logic                wb_ack,
    input  logic                char_cen,
    input  logic [`CHAR_AW-1:0] char_addr,
    input  logic [7:0]          char_q,
    input  logic [`PAL_AW-1:0]  pal_addr,
    input  logic [11:0]         pal_rgb,
    output int                  errors,
    output int                  checks
);

    char_byte_t         char_mem [1<<`CHAR_AW];     // reference contents
    rgb444_t            pal_mem [1<<`PAL_AW];
    logic [`CSUM_W-1:0] char_sum = '0;
    logic [`CSUM_W-1:0] pal_sum  = '0;
    logic               pend     = 1'b0;            // strobe seen, ack due next edge
    logic               pend_we  = 1'b0;
    logic [`WB_AW-1:0]  pend_adr = '0;              // captured at the strobe edge
    logic [`WB_DW-1:0]  pend_dat = '0;
    char_byte_t         exp_char = '0;
    rgb444_t            exp_pal  = '0;
    logic               char_v   = 1'b0;            // char_q known once cen was high
    logic               pal_v    = 1'b0;
    int                 err_cnt  = 0;
    int                 chk_cnt  = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    initial begin
        foreach (char_mem[i]) char_mem[i] = '0;     // proms come up blank
        foreach (pal_mem[i]) pal_mem[i] = '0;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // one acked access, applied to the model in bus order
    task automatic apply_access();
        logic [`WB_AW-1:0] char_off;
        logic [`WB_AW-1:0] pal_off;
        rgb444_t           col;
        char_off = pend_adr - `CHAR_BASE;           // wraps high when below the base
        pal_off  = pend_adr - `PAL_BASE;
        col.r    = pend_dat[11:8];
        col.g    = pend_dat[7:4];
        col.b    = pend_dat[3:0];
        if (!pend_we) begin
            if (pend_adr == `CSUM_ADDR)
                check_value("wb_dat_o", {pal_sum, char_sum}, wb_dat_o);
            else
                check_value("wb_dat_o", 32'h0, wb_dat_o);   // nothing else reads back
        end else if (pend_adr == `CSUM_ADDR) begin
            char_sum = '0;
            pal_sum  = '0;
        end else if (char_off < 16'(1 << `CHAR_AW)) begin
            char_mem[char_off[`CHAR_AW-1:0]] = pend_dat[7:0];
            char_sum = char_sum + {8'h00, pend_dat[7:0]};
        end else if (pal_off < 16'(1 << `PAL_AW)) begin
            pal_mem[pal_off[`PAL_AW-1:0]] = col;
            pal_sum = pal_sum + {4'h0, col.r, col.g, col.b};
        end                                          // anything else is dropped
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            // read registers, compared against last edge's prediction
            if (char_v)
                check_value("char_q", 32'(exp_char), 32'(char_q));
            if (pal_v)
                check_value("pal_rgb", 32'(exp_pal), 32'(pal_rgb));
        end
        // reads see the old word, so predict before any write lands
        if (char_cen === 1'b1) begin
            exp_char = char_mem[char_addr];
            char_v   = 1'b1;
        end
        exp_pal = pal_mem[pal_addr];                 // palette reads every edge
        pal_v   = 1'b1;
        if (rst) begin
            pend     = 1'b0;
            char_sum = '0;
            pal_sum  = '0;
        end else begin
            if (pend) begin
                check_value("wb_ack", 32'd1, 32'(wb_ack));
                if (wb_ack === 1'b1)
                    apply_access();
            end else if (wb_ack !== 1'b0) begin
                check_value("wb_ack", 32'd0, 32'(wb_ack));   // ack with no strobe
            end
            pend     = wb_cyc & wb_stb & ~wb_ack;
            pend_we  = wb_we;
            pend_adr = wb_adr;
            pend_dat = wb_dat_i;
        end
    end

endmodule

// File: tb/tb_rom_dl.sv
`timescale 1ns/1ps
`include "rom_dl_config.svh"

module tb_rom_dl;

    localparam logic [2:0] OP_WR    = 3'd0;     // bus write
    localparam logic [2:0] OP_RD    = 3'd1;     // bus read
    localparam logic [2:0] OP_CRD   = 3'd2;     // char read, cen high
    localparam logic [2:0] OP_CHOLD = 3'd3;     // char address moves, cen low
    localparam logic [2:0] OP_PAL   = 3'd4;     // palette lookup
    localparam int NSTEP       = 34;
    localparam int ACK_TIMEOUT = 20;            // cycles

    typedef struct packed {
        logic [2:0]  op;
        logic        rnd;                       // data from the lcg
        logic [15:0] adr;
        logic [31:0] dat;
    } step_t;

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [`WB_AW-1:0]   wb_adr;
    logic [`WB_DW-1:0]   wb_dat_i;
    logic [`WB_DW-1:0]   wb_dat_o;
    logic                wb_ack;
    logic                char_cen;
    logic [`CHAR_AW-1:0] char_addr;
    logic [7:0]          char_q;
    logic [`PAL_AW-1:0]  pal_addr;
    logic [11:0]         pal_rgb;
    int                  errors;
    int                  checks;
    logic [31:0]         rnd_state = 32'hfed3;
    bit                  timed_out = 1'b0;

    // op, rnd, address, data
    step_t steps [NSTEP] = '{
        '{OP_RD,    1'b0, `CSUM_ADDR, 32'h0},   // sums clear out of reset
        '{OP_WR,    1'b0, 16'h0000,   32'h0000_00a5},
        '{OP_WR,    1'b1, 16'h0001,   32'h0},
        '{OP_WR,    1'b0, 16'h03ff,   32'hdead_be3c},  // upper bits ignored
        '{OP_CRD,   1'b0, 16'h0000,   32'h0},
        '{OP_CRD,   1'b0, 16'h0001,   32'h0},
        '{OP_CRD,   1'b0, 16'h03ff,   32'h0},
        '{OP_CRD,   1'b0, 16'h0010,   32'h0},   // never written
        '{OP_CRD,   1'b0, 16'h0000,   32'h0},
        '{OP_CHOLD, 1'b0, 16'h0001,   32'h0},   // char_q must stay a5
        '{OP_CHOLD, 1'b0, 16'h03ff,   32'h0},
        '{OP_WR,    1'b0, 16'h1000,   32'h0000_0f80},
        '{OP_WR,    1'b1, 16'h1001,   32'h0},
        '{OP_WR,    1'b0, 16'h10ff,   32'h0000_0123},
        '{OP_PAL,   1'b0, 16'h1000,   32'h0},
        '{OP_PAL,   1'b0, 16'h1001,   32'h0},
        '{OP_PAL,   1'b0, 16'h10ff,   32'h0},
        '{OP_PAL,   1'b0, 16'h1010,   32'h0},
        '{OP_RD,    1'b0, `CSUM_ADDR, 32'h0},
        '{OP_WR,    1'b1, `CSUM_ADDR, 32'h0},   // any data clears
        '{OP_RD,    1'b0, `CSUM_ADDR, 32'h0},
        '{OP_WR,    1'b1, 16'h0002,   32'h0},
        '{OP_WR,    1'b1, 16'h1002,   32'h0},
        '{OP_RD,    1'b0, `CSUM_ADDR, 32'h0},
        '{OP_WR,    1'b0, 16'h0400,   32'h0000_00ff},  // past char depth
        '{OP_WR,    1'b0, 16'h1100,   32'h0000_0fff},  // past palette depth
        '{OP_WR,    1'b0, 16'h3000,   32'h1234_5678},  // unmapped
        '{OP_RD,    1'b0, 16'h0400,   32'h0},
        '{OP_RD,    1'b0, 16'h0000,   32'h0},   // proms not readable on the bus
        '{OP_RD,    1'b0, `CSUM_ADDR, 32'h0},
        '{OP_CRD,   1'b0, 16'h0000,   32'h0},   // no aliasing from 0x0400
        '{OP_PAL,   1'b0, 16'h1000,   32'h0},
        '{OP_WR,    1'b1, 16'h0000,   32'h0},
        '{OP_RD,    1'b0, `CSUM_ADDR, 32'h0}
    };

    rom_dl_top u_dut (.*);

    rom_dl_checker u_checker (.*);

    bind rom_dl_top rom_dl_sva u_sva (
        .clk    (clk),
        .rst    (rst),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_ack (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string op_name(input logic [2:0] op);
        case (op)
            OP_WR:    return "bus write";
            OP_RD:    return "bus read";
            OP_CRD:   return "char read";
            OP_CHOLD: return "char hold";
            default:  return "pal read";
        endcase
    endfunction

    // one classic cycle, address and data held until ack
    task automatic bus_access(input logic we, input logic [15:0] adr,
                              input logic [31:0] dat, output bit ok);
        int waited;
        ok       = 1'b0;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = dat;
        while (!ok && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
            if (wb_ack === 1'b1)
                ok = 1'b1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);                         // let the ack cycle close
        #2;
        if (!ok)
            $display("no ack from slave at address %h within %0d cycles", adr, ACK_TIMEOUT);
    endtask

    // address then two edges: one to load the read register, one to compare
    task automatic char_read(input logic cen, input logic [`CHAR_AW-1:0] adr);
        char_cen  = cen;
        char_addr = adr;
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        char_cen = 1'b0;
    endtask

    task automatic pal_read(input logic [`PAL_AW-1:0] adr);
        pal_addr = adr;
        repeat (2) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int          errs_before;
        int          ntests;
        int          sva_fails;
        bit          ok;
        logic [31:0] dat;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        char_cen  = 1'b0;
        char_addr = '0;
        pal_addr  = '0;
        ntests    = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < NSTEP && !timed_out; i++) begin
            errs_before = errors;
            ok          = 1'b1;
            dat         = steps[i].dat;
            if (steps[i].rnd) begin
                rnd_state = lcg_next(rnd_state);
                dat       = rnd_state;
            end
            case (steps[i].op)
                OP_WR:    bus_access(1'b1, steps[i].adr, dat, ok);
                OP_RD:    bus_access(1'b0, steps[i].adr, dat, ok);
                OP_CRD:   char_read(1'b1, steps[i].adr[`CHAR_AW-1:0]);
                OP_CHOLD: char_read(1'b0, steps[i].adr[`CHAR_AW-1:0]);
                default:  pal_read(steps[i].adr[`PAL_AW-1:0]);
            endcase
            timed_out = !ok;
            ntests++;
            if (ok && errors == errs_before)
                $display("test %0d %s %h: ok", i, op_name(steps[i].op), steps[i].adr);
            else
                $display("test %0d %s %h: %0d mismatches%s", i, op_name(steps[i].op),
                         steps[i].adr, errors - errs_before, ok ? "" : ", bus timeout");
        end
        sva_fails = u_dut.u_sva.fail_cnt;       // protocol properties that fired
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 ntests, checks, errors, sva_fails, timed_out ? 1 : 0);
        if (errors == 0 && sva_fails == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
rtl/rom_map_pkg.sv
rtl/video_pkg.sv
rtl/dl_wr_if.sv
rtl/prom_mem.sv
rtl/dl_wb_slave.sv
rtl/dl_checksum.sv
rtl/rom_dl_top.sv
tb/rom_dl_sva.sv
tb/rom_dl_checker.sv
tb/tb_rom_dl.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rom_dl
FILELIST   := all.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_OPTS   := +verilator+error+limit+100
LOG        := sim.log
BIN        := obj_dir/V$(TOP)
SRCS       := $(wildcard rtl/*.sv tb/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: $(BIN)
	./$(BIN) $(RUN_OPTS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation ended early"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
